// File: rtl/csr_defs.svh
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// Widths
`define CSR_NUM_W        14
`define CSR_DATA_W       32
`define CSR_INT_W        13
`define CSR_HW_INT_W     8

// CSR numbers
`define CSR_CRMD         14'h000
`define CSR_PRMD         14'h001
`define CSR_ECFG         14'h004
`define CSR_ESTAT        14'h005
`define CSR_ERA          14'h006
`define CSR_BADV         14'h007
`define CSR_EENTRY       14'h00c
`define CSR_SAVE0        14'h030
`define CSR_SAVE1        14'h031
`define CSR_SAVE2        14'h032
`define CSR_SAVE3        14'h033
`define CSR_TID          14'h040
`define CSR_TCFG         14'h041
`define CSR_TVAL         14'h042
`define CSR_TICLR        14'h044

// Field ranges
`define CSR_CRMD_PLV     1:0
`define CSR_CRMD_IE      2
`define CSR_CRMD_DA      3
`define CSR_CRMD_PG      4
`define CSR_PRMD_PPLV    1:0
`define CSR_PRMD_PIE     2
`define CSR_ECFG_LIE     12:0
`define CSR_ESTAT_IS10   1:0
`define CSR_EENTRY_VA    31:6
`define CSR_TCFG_EN      0
`define CSR_TCFG_PERIOD  1
`define CSR_TCFG_INITV   31:2
`define CSR_TICLR_CLR    0

// Bit 10 of the local enables is reserved
`define ECFG_LIE_MASK    13'h1bff

`define ECODE_ADE        6'h08
`define ECODE_ALE        6'h09
`define ESUBCODE_ADEF    9'h000

`define TIMER_IDLE       32'hffff_ffff

`endif

// File: rtl/csr_pkg.sv
`include "csr_defs.svh"

package csr_pkg;

   // Access port
   typedef logic [`CSR_NUM_W-1:0]  csr_num_t;
   typedef logic [`CSR_DATA_W-1:0] csr_data_t;

   // Privilege level, 0 is kernel
   typedef logic [1:0] plv_t;

   // Exception cause as reported by writeback
   typedef logic [5:0] ecode_t;
   typedef logic [8:0] esubcode_t;

   // Interrupt vector layout
   //   1:0  software
   //   9:2  hardware
   //   10   reserved
   //   11   timer
   //   12   inter-processor
   typedef logic [`CSR_INT_W-1:0] int_vec_t;

   // External interrupt pins
   typedef logic [`CSR_HW_INT_W-1:0] hw_int_t;

endpackage

// File: rtl/csr_exc.sv
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_exc (
   input  logic                 clk,
   input  logic                 resetn,
   input  csr_pkg::csr_num_t    csr_num,
   input  logic                 csr_we,
   input  csr_pkg::csr_data_t   csr_wmask,
   input  csr_pkg::csr_data_t   csr_wvalue,
   input  logic                 wb_ex,
   input  logic                 ertn_flush,
   input  csr_pkg::csr_data_t   wb_pc,
   input  csr_pkg::csr_data_t   wb_vaddr,
   input  csr_pkg::ecode_t      wb_ecode,
   input  csr_pkg::esubcode_t   wb_esubcode,
   output logic                 crmd_ie,
   output csr_pkg::csr_data_t   ex_entry,
   output csr_pkg::csr_data_t   era,
   output csr_pkg::csr_data_t   rdata
);
   import csr_pkg::*;

   plv_t        crmd_plv;
   logic        crmd_da;
   logic        crmd_pg;
   plv_t        prmd_pplv;
   logic        prmd_pie;
   csr_data_t   era_q;
   logic [25:0] eentry_va;
   csr_data_t   badv_q;
   logic        addr_err;
   logic        badv_from_pc;

   assign addr_err     = (wb_ecode == `ECODE_ADE) || (wb_ecode == `ECODE_ALE);
   assign badv_from_pc = (wb_ecode == `ECODE_ADE) && (wb_esubcode == `ESUBCODE_ADEF);

   // Exception entry drops to kernel, direct address
   always_ff @(posedge clk) begin
      if (!resetn || wb_ex) begin
         crmd_plv <= 2'd0;
         crmd_ie  <= 1'b0;
         crmd_da  <= 1'b1;
         crmd_pg  <= 1'b0;
      end else if (ertn_flush) begin
         crmd_plv <= prmd_pplv;
         crmd_ie  <= prmd_pie;
      end else if (csr_we && csr_num == `CSR_CRMD) begin
         crmd_plv <= (csr_wmask[`CSR_CRMD_PLV] & csr_wvalue[`CSR_CRMD_PLV]) |
                     (~csr_wmask[`CSR_CRMD_PLV] & crmd_plv);
         crmd_ie  <= (csr_wmask[`CSR_CRMD_IE] & csr_wvalue[`CSR_CRMD_IE]) |
                     (~csr_wmask[`CSR_CRMD_IE] & crmd_ie);
         crmd_da  <= (csr_wmask[`CSR_CRMD_DA] & csr_wvalue[`CSR_CRMD_DA]) |
                     (~csr_wmask[`CSR_CRMD_DA] & crmd_da);
         crmd_pg  <= (csr_wmask[`CSR_CRMD_PG] & csr_wvalue[`CSR_CRMD_PG]) |
                     (~csr_wmask[`CSR_CRMD_PG] & crmd_pg);
      end
   end

   // Saved mode and return address
   always_ff @(posedge clk) begin
      if (wb_ex) begin
         prmd_pplv <= crmd_plv;
         prmd_pie  <= crmd_ie;
         era_q     <= wb_pc;
      end else begin
         if (csr_we && csr_num == `CSR_PRMD) begin
            prmd_pplv <= (csr_wmask[`CSR_PRMD_PPLV] & csr_wvalue[`CSR_PRMD_PPLV]) |
                         (~csr_wmask[`CSR_PRMD_PPLV] & prmd_pplv);
            prmd_pie  <= (csr_wmask[`CSR_PRMD_PIE] & csr_wvalue[`CSR_PRMD_PIE]) |
                         (~csr_wmask[`CSR_PRMD_PIE] & prmd_pie);
         end
         if (csr_we && csr_num == `CSR_ERA) begin
            era_q <= (csr_wmask & csr_wvalue) | (~csr_wmask & era_q);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (csr_we && csr_num == `CSR_EENTRY) begin
         eentry_va <= (csr_wmask[`CSR_EENTRY_VA] & csr_wvalue[`CSR_EENTRY_VA]) |
                      (~csr_wmask[`CSR_EENTRY_VA] & eentry_va);
      end
   end

   // Fetch faults report the PC, others the data address
   always_ff @(posedge clk) begin
      if (wb_ex) begin
         if (addr_err) begin
            badv_q <= badv_from_pc ? wb_pc : wb_vaddr;
         end
      end else if (csr_we && csr_num == `CSR_BADV) begin
         badv_q <= (csr_wmask & csr_wvalue) | (~csr_wmask & badv_q);
      end
   end

   assign ex_entry = {eentry_va, 6'd0};
   assign era      = era_q;

   always_comb begin
      case (csr_num)
         `CSR_CRMD:   rdata = {27'd0, crmd_pg, crmd_da, crmd_ie, crmd_plv};
         `CSR_PRMD:   rdata = {29'd0, prmd_pie, prmd_pplv};
         `CSR_ERA:    rdata = era_q;
         `CSR_EENTRY: rdata = {eentry_va, 6'd0};
         `CSR_BADV:   rdata = badv_q;
         default:     rdata = '0;
      endcase
   end

endmodule

// File: rtl/csr_int.sv
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_int (
   input  logic                 clk,
   input  logic                 resetn,
   input  csr_pkg::csr_num_t    csr_num,
   input  logic                 csr_we,
   input  csr_pkg::csr_data_t   csr_wmask,
   input  csr_pkg::csr_data_t   csr_wvalue,
   input  logic                 wb_ex,
   input  csr_pkg::ecode_t      wb_ecode,
   input  csr_pkg::esubcode_t   wb_esubcode,
   input  csr_pkg::hw_int_t     hw_int_in,
   input  logic                 ipi_int_in,
   input  logic                 crmd_ie,
   input  logic                 timer_int_set,
   input  logic                 timer_int_clr,
   output logic                 has_int,
   output csr_pkg::csr_data_t   rdata
);
   import csr_pkg::*;

   int_vec_t  ecfg_lie;
   logic [1:0] is_sw;
   hw_int_t   is_hw;
   logic      is_ti;
   logic      is_ipi;
   int_vec_t  estat_is;
   ecode_t    estat_ecode;
   esubcode_t estat_esubcode;

   always_ff @(posedge clk) begin
      if (!resetn) begin
         ecfg_lie <= '0;
      end else if (csr_we && csr_num == `CSR_ECFG) begin
         ecfg_lie <= `ECFG_LIE_MASK &
                     ((csr_wmask[`CSR_ECFG_LIE] & csr_wvalue[`CSR_ECFG_LIE]) |
                      (~csr_wmask[`CSR_ECFG_LIE] & ecfg_lie));
      end
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         is_sw          <= 2'd0;
         is_ti          <= 1'b0;
         estat_ecode    <= '0;
         estat_esubcode <= '0;
      end else begin
         if (csr_we && csr_num == `CSR_ESTAT) begin
            is_sw <= (csr_wmask[`CSR_ESTAT_IS10] & csr_wvalue[`CSR_ESTAT_IS10]) |
                     (~csr_wmask[`CSR_ESTAT_IS10] & is_sw);
         end
         // Timer set wins over a clear in the same cycle
         if (timer_int_set) begin
            is_ti <= 1'b1;
         end else if (timer_int_clr) begin
            is_ti <= 1'b0;
         end
         if (wb_ex) begin
            estat_ecode    <= wb_ecode;
            estat_esubcode <= wb_esubcode;
         end
      end
   end

   // External lines sampled every cycle
   always_ff @(posedge clk) begin
      is_hw  <= hw_int_in;
      is_ipi <= ipi_int_in;
   end

   assign estat_is = {is_ipi, is_ti, 1'b0, is_hw, is_sw};
   assign has_int  = (|(estat_is & ecfg_lie)) & crmd_ie;

   always_comb begin
      case (csr_num)
         `CSR_ECFG:  rdata = {19'd0, ecfg_lie};
         `CSR_ESTAT: rdata = {1'b0, estat_esubcode, estat_ecode, 3'd0, estat_is};
         default:    rdata = '0;
      endcase
   end

endmodule

// File: rtl/csr_timer.sv
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_timer (
   input  logic                 clk,
   input  logic                 resetn,
   input  csr_pkg::csr_num_t    csr_num,
   input  logic                 csr_we,
   input  csr_pkg::csr_data_t   csr_wmask,
   input  csr_pkg::csr_data_t   csr_wvalue,
   output logic                 timer_int_set,
   output logic                 timer_int_clr,
   output csr_pkg::csr_data_t   rdata
);
   import csr_pkg::*;

   logic        tcfg_en;
   logic        tcfg_periodic;
   logic [29:0] tcfg_initval;
   csr_data_t   tcfg_value;
   csr_data_t   tcfg_next;
   logic        tcfg_wr;
   csr_data_t   timer_cnt;

   assign tcfg_value = {tcfg_initval, tcfg_periodic, tcfg_en};
   assign tcfg_wr    = csr_we && (csr_num == `CSR_TCFG);

   // TCFG as it will look after this write
   assign tcfg_next = (csr_wmask & csr_wvalue) | (~csr_wmask & tcfg_value);

   always_ff @(posedge clk) begin
      if (!resetn) begin
         tcfg_en <= 1'b0;
      end else if (tcfg_wr) begin
         tcfg_en <= tcfg_next[`CSR_TCFG_EN];
      end
   end

   always_ff @(posedge clk) begin
      if (tcfg_wr) begin
         tcfg_periodic <= tcfg_next[`CSR_TCFG_PERIOD];
         tcfg_initval  <= tcfg_next[`CSR_TCFG_INITV];
      end
   end

   // Counter stops once it wraps to all ones
   always_ff @(posedge clk) begin
      if (!resetn) begin
         timer_cnt <= `TIMER_IDLE;
      end else if (tcfg_wr && tcfg_next[`CSR_TCFG_EN]) begin
         timer_cnt <= {tcfg_next[`CSR_TCFG_INITV], 2'b00};
      end else if (tcfg_en && timer_cnt != `TIMER_IDLE) begin
         if (timer_cnt == '0 && tcfg_periodic) begin
            timer_cnt <= {tcfg_initval, 2'b00};
         end else begin
            timer_cnt <= timer_cnt - 32'd1;
         end
      end
   end

   // Only one cycle at zero while running
   assign timer_int_set = tcfg_en && (timer_cnt == '0);

   assign timer_int_clr = csr_we && (csr_num == `CSR_TICLR) &&
                          csr_wmask[`CSR_TICLR_CLR] && csr_wvalue[`CSR_TICLR_CLR];

   // TICLR reads as zero through the default
   always_comb begin
      case (csr_num)
         `CSR_TCFG: rdata = tcfg_value;
         `CSR_TVAL: rdata = timer_cnt;
         default:   rdata = '0;
      endcase
   end

endmodule

// File: rtl/csr_save.sv
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_save (
   input  logic                 clk,
   input  logic                 resetn,
   input  csr_pkg::csr_num_t    csr_num,
   input  logic                 csr_we,
   input  csr_pkg::csr_data_t   csr_wmask,
   input  csr_pkg::csr_data_t   csr_wvalue,
   input  csr_pkg::csr_data_t   coreid_in,
   output csr_pkg::csr_data_t   rdata
);
   import csr_pkg::*;

   csr_data_t save_q [4];
   csr_data_t tid_q;

   // SAVE0..3 sit on consecutive numbers
   always_ff @(posedge clk) begin
      for (int i = 0; i < 4; i++) begin
         if (csr_we && csr_num == csr_num_t'(`CSR_SAVE0 + i)) begin
            save_q[i] <= (csr_wmask & csr_wvalue) | (~csr_wmask & save_q[i]);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!resetn) begin
         tid_q <= coreid_in;
      end else if (csr_we && csr_num == `CSR_TID) begin
         tid_q <= (csr_wmask & csr_wvalue) | (~csr_wmask & tid_q);
      end
   end

   always_comb begin
      rdata = '0;
      for (int i = 0; i < 4; i++) begin
         if (csr_num == csr_num_t'(`CSR_SAVE0 + i)) begin
            rdata = save_q[i];
         end
      end
      if (csr_num == `CSR_TID) begin
         rdata = tid_q;
      end
   end

endmodule

// File: rtl/csr_top.sv
`timescale 1ns/1ps

module csr_top (
   input  logic                 clk,
   input  logic                 resetn,
   input  csr_pkg::csr_num_t    csr_num,
   input  logic                 csr_we,
   input  csr_pkg::csr_data_t   csr_wmask,
   input  csr_pkg::csr_data_t   csr_wvalue,
   output csr_pkg::csr_data_t   csr_rvalue,
   input  csr_pkg::hw_int_t     hw_int_in,
   input  logic                 ipi_int_in,
   input  csr_pkg::csr_data_t   coreid_in,
   output csr_pkg::csr_data_t   ex_entry,
   output csr_pkg::csr_data_t   era,
   output logic                 has_int,
   input  logic                 ertn_flush,
   input  logic                 wb_ex,
   input  csr_pkg::csr_data_t   wb_pc,
   input  csr_pkg::csr_data_t   wb_vaddr,
   input  csr_pkg::ecode_t      wb_ecode,
   input  csr_pkg::esubcode_t   wb_esubcode
);
   import csr_pkg::*;

   logic      crmd_ie;
   logic      timer_int_set;
   logic      timer_int_clr;
   csr_data_t exc_rdata;
   csr_data_t int_rdata;
   csr_data_t timer_rdata;
   csr_data_t save_rdata;

   csr_exc u_csr_exc (
      .clk         (clk),
      .resetn      (resetn),
      .csr_num     (csr_num),
      .csr_we      (csr_we),
      .csr_wmask   (csr_wmask),
      .csr_wvalue  (csr_wvalue),
      .wb_ex       (wb_ex),
      .ertn_flush  (ertn_flush),
      .wb_pc       (wb_pc),
      .wb_vaddr    (wb_vaddr),
      .wb_ecode    (wb_ecode),
      .wb_esubcode (wb_esubcode),
      .crmd_ie     (crmd_ie),
      .ex_entry    (ex_entry),
      .era         (era),
      .rdata       (exc_rdata)
   );

   csr_int u_csr_int (
      .clk           (clk),
      .resetn        (resetn),
      .csr_num       (csr_num),
      .csr_we        (csr_we),
      .csr_wmask     (csr_wmask),
      .csr_wvalue    (csr_wvalue),
      .wb_ex         (wb_ex),
      .wb_ecode      (wb_ecode),
      .wb_esubcode   (wb_esubcode),
      .hw_int_in     (hw_int_in),
      .ipi_int_in    (ipi_int_in),
      .crmd_ie       (crmd_ie),
      .timer_int_set (timer_int_set),
      .timer_int_clr (timer_int_clr),
      .has_int       (has_int),
      .rdata         (int_rdata)
   );

   csr_timer u_csr_timer (
      .clk           (clk),
      .resetn        (resetn),
      .csr_num       (csr_num),
      .csr_we        (csr_we),
      .csr_wmask     (csr_wmask),
      .csr_wvalue    (csr_wvalue),
      .timer_int_set (timer_int_set),
      .timer_int_clr (timer_int_clr),
      .rdata         (timer_rdata)
   );

   csr_save u_csr_save (
      .clk        (clk),
      .resetn     (resetn),
      .csr_num    (csr_num),
      .csr_we     (csr_we),
      .csr_wmask  (csr_wmask),
      .csr_wvalue (csr_wvalue),
      .coreid_in  (coreid_in),
      .rdata      (save_rdata)
   );

   // Blocks return zero for numbers they do not own
   assign csr_rvalue = exc_rdata | int_rdata | timer_rdata | save_rdata;

endmodule

// File: testbench/csr_checker.sv
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_checker (
   input  logic                 clk,
   input  logic                 resetn,
   input  logic                 has_int,
   input  csr_pkg::csr_num_t    csr_num,
   input  csr_pkg::csr_data_t   csr_rvalue,
   input  logic                 tcfg_en,
   input  csr_pkg::csr_data_t   timer_cnt,
   input  logic                 wb_ex,
   input  csr_pkg::plv_t        crmd_plv
);
   import csr_pkg::*;

   // Exception entry masks interrupts
   a_ex_masks_int: assert property (@(posedge clk) disable iff (!resetn)
      wb_ex |=> !has_int)
      else $error("has_int raised after exception entry cleared CRMD.IE");

   a_ecfg_bit10: assert property (@(posedge clk) disable iff (!resetn)
      (csr_num == `CSR_ECFG) |-> (csr_rvalue[10] == 1'b0))
      else $error("ECFG bit 10 reads as set");

   // Stopped timer keeps its count
   a_timer_hold: assert property (@(posedge clk) disable iff (!resetn)
      (!tcfg_en && !$past(tcfg_en)) |-> $stable(timer_cnt))
      else $error("TVAL changed while the timer is disabled");

   a_ex_kernel: assert property (@(posedge clk) disable iff (!resetn)
      wb_ex |=> (crmd_plv == 2'd0))
      else $error("CRMD.PLV not kernel after exception entry");

endmodule

// File: testbench/csr_tb.sv
`timescale 1ns/1ps
`include "csr_defs.svh"

module csr_tb;
   import csr_pkg::*;

   localparam int N_RW  = 300;
   localparam int N_EX  = 40;
   localparam int N_RET = 30;
   localparam int N_INT = 30;
   localparam int N_TMR = 6;
   localparam int PLANNED_CYCLES = 16 + 16 + 12 + N_RW * 2 + N_EX * 6 + N_RET * 5 +
                                   N_INT * 7 + N_TMR * 64;
   localparam int CYCLE_LIMIT = 20 * PLANNED_CYCLES;

   logic       clk;
   logic       resetn;
   csr_num_t   csr_num;
   logic       csr_we;
   csr_data_t  csr_wmask;
   csr_data_t  csr_wvalue;
   csr_data_t  csr_rvalue;
   hw_int_t    hw_int_in;
   logic       ipi_int_in;
   csr_data_t  coreid_in;
   csr_data_t  ex_entry;
   csr_data_t  era;
   logic       has_int;
   logic       ertn_flush;
   logic       wb_ex;
   csr_data_t  wb_pc;
   csr_data_t  wb_vaddr;
   ecode_t     wb_ecode;
   esubcode_t  wb_esubcode;

   // Model state
   logic [4:0]  m_crmd;
   logic [2:0]  m_prmd;
   csr_data_t   m_era;
   logic [25:0] m_eentry;
   csr_data_t   m_badv;
   int_vec_t    m_lie;
   logic [1:0]  m_sw;
   hw_int_t     m_hw;
   logic        m_ipi;
   logic        m_ti;
   ecode_t      m_ecode;
   esubcode_t   m_esub;
   csr_data_t   m_tcfg;
   csr_data_t   m_cnt;
   csr_data_t   m_save [4];
   csr_data_t   m_tid;
   logic        prmd_known;
   logic        era_known;
   logic        eentry_known;
   logic        badv_known;
   logic        tcfg_known;
   logic [3:0]  save_known;
   int          cycles;
   csr_num_t    kept_nums [15];

   csr_top u_csr_top (.*);

   bind csr_top csr_checker u_csr_checker (
      .clk        (clk),
      .resetn     (resetn),
      .has_int    (has_int),
      .csr_num    (csr_num),
      .csr_rvalue (csr_rvalue),
      .tcfg_en    (u_csr_timer.tcfg_en),
      .timer_cnt  (u_csr_timer.timer_cnt),
      .wb_ex      (wb_ex),
      .crmd_plv   (u_csr_exc.crmd_plv)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT) begin
         $display("=== FAIL ===");
         $fatal(1, "Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      end
   end

   function automatic csr_data_t merge(input csr_data_t old, input csr_data_t mask,
                                       input csr_data_t val);
      return (mask & val) | (~mask & old);
   endfunction

   function automatic logic model_has_int();
      int_vec_t is;
      is = {m_ipi, m_ti, 1'b0, m_hw, m_sw};
      return (|(is & m_lie)) & m_crmd[2];
   endfunction

   function automatic logic model_known(input csr_num_t n);
      case (n)
         `CSR_PRMD:   return prmd_known;
         `CSR_ERA:    return era_known;
         `CSR_EENTRY: return eentry_known;
         `CSR_BADV:   return badv_known;
         `CSR_TCFG:   return tcfg_known;
         `CSR_SAVE0:  return save_known[0];
         `CSR_SAVE1:  return save_known[1];
         `CSR_SAVE2:  return save_known[2];
         `CSR_SAVE3:  return save_known[3];
         default:     return 1'b1;
      endcase
   endfunction

   function automatic csr_data_t model_read(input csr_num_t n);
      case (n)
         `CSR_CRMD:   return {27'd0, m_crmd};
         `CSR_PRMD:   return {29'd0, m_prmd};
         `CSR_ECFG:   return {19'd0, m_lie};
         `CSR_ESTAT:  return {1'b0, m_esub, m_ecode, 3'd0, m_ipi, m_ti, 1'b0, m_hw, m_sw};
         `CSR_ERA:    return m_era;
         `CSR_BADV:   return m_badv;
         `CSR_EENTRY: return {m_eentry, 6'd0};
         `CSR_SAVE0:  return m_save[0];
         `CSR_SAVE1:  return m_save[1];
         `CSR_SAVE2:  return m_save[2];
         `CSR_SAVE3:  return m_save[3];
         `CSR_TID:    return m_tid;
         `CSR_TCFG:   return m_tcfg;
         `CSR_TVAL:   return m_cnt;
         default:     return '0;
      endcase
   endfunction

   // Next state from the inputs seen at this edge
   task automatic model_update();
      logic [4:0] c_old;
      logic [2:0] p_old;
      csr_data_t  cnt_old;
      csr_data_t  tcfg_old;
      csr_data_t  mv;
      logic       tset;
      logic       tclr;
      logic       wr;
      c_old    = m_crmd;
      p_old    = m_prmd;
      cnt_old  = m_cnt;
      tcfg_old = m_tcfg;
      m_hw     = hw_int_in;
      m_ipi    = ipi_int_in;
      if (!resetn) begin
         m_crmd    = 5'h08;
         m_lie     = '0;
         m_sw      = '0;
         m_ti      = 1'b0;
         m_ecode   = '0;
         m_esub    = '0;
         m_tcfg[0] = 1'b0;
         m_cnt     = `TIMER_IDLE;
         m_tid     = coreid_in;
      end else begin
         tset = tcfg_old[0] && (cnt_old == '0);
         tclr = csr_we && (csr_num == `CSR_TICLR) && csr_wmask[0] && csr_wvalue[0];
         if (wb_ex) begin
            m_crmd = 5'b01000;
         end else if (ertn_flush) begin
            m_crmd[2:0] = p_old;
         end else if (csr_we && csr_num == `CSR_CRMD) begin
            mv = merge({27'd0, c_old}, csr_wmask, csr_wvalue);
            m_crmd = mv[4:0];
         end
         if (wb_ex) begin
            m_prmd     = c_old[2:0];
            prmd_known = 1'b1;
            m_era      = wb_pc;
            era_known  = 1'b1;
            m_ecode    = wb_ecode;
            m_esub     = wb_esubcode;
            if (wb_ecode == `ECODE_ADE || wb_ecode == `ECODE_ALE) begin
               m_badv = (wb_ecode == `ECODE_ADE && wb_esubcode == `ESUBCODE_ADEF) ?
                        wb_pc : wb_vaddr;
               badv_known = 1'b1;
            end
         end else begin
            if (csr_we && csr_num == `CSR_PRMD) begin
               mv = merge({29'd0, p_old}, csr_wmask, csr_wvalue);
               m_prmd = mv[2:0];
               if (csr_wmask[2:0] == 3'b111) prmd_known = 1'b1;
            end
            if (csr_we && csr_num == `CSR_ERA) begin
               m_era = merge(m_era, csr_wmask, csr_wvalue);
               if (csr_wmask == '1) era_known = 1'b1;
            end
            if (csr_we && csr_num == `CSR_BADV) begin
               m_badv = merge(m_badv, csr_wmask, csr_wvalue);
               if (csr_wmask == '1) badv_known = 1'b1;
            end
         end
         if (csr_we && csr_num == `CSR_EENTRY) begin
            mv = merge({m_eentry, 6'd0}, csr_wmask, csr_wvalue);
            m_eentry = mv[31:6];
            if (csr_wmask[31:6] == '1) eentry_known = 1'b1;
         end
         if (csr_we && csr_num == `CSR_ECFG) begin
            mv = merge({19'd0, m_lie}, csr_wmask, csr_wvalue);
            m_lie = mv[12:0] & `ECFG_LIE_MASK;
         end
         if (csr_we && csr_num == `CSR_ESTAT) begin
            mv = merge({30'd0, m_sw}, csr_wmask, csr_wvalue);
            m_sw = mv[1:0];
         end
         if (tset) m_ti = 1'b1;
         else if (tclr) m_ti = 1'b0;
         wr = csr_we && (csr_num == `CSR_TCFG);
         if (wr) begin
            m_tcfg = merge(tcfg_old, csr_wmask, csr_wvalue);
            if (csr_wmask[31:1] == '1) tcfg_known = 1'b1;
         end
         if (wr && m_tcfg[0]) begin
            m_cnt = {m_tcfg[31:2], 2'b00};
         end else if (tcfg_old[0] && cnt_old != `TIMER_IDLE) begin
            if (cnt_old == '0 && tcfg_old[1]) m_cnt = {tcfg_old[31:2], 2'b00};
            else m_cnt = cnt_old - 32'd1;
         end
         for (int i = 0; i < 4; i++) begin
            if (csr_we && csr_num == csr_num_t'(`CSR_SAVE0 + i)) begin
               m_save[i] = merge(m_save[i], csr_wmask, csr_wvalue);
               if (csr_wmask == '1) save_known[i] = 1'b1;
            end
         end
         if (csr_we && csr_num == `CSR_TID) m_tid = merge(m_tid, csr_wmask, csr_wvalue);
      end
   endtask

   task automatic check_data(input string what, input csr_data_t got, input csr_data_t exp);
      if (got !== exp) begin
         $display("Error: %0t %s got %h expected %h", $time, what, got, exp);
         $display("=== FAIL ===");
         $fatal(1, "Value mismatch on %s", what);
      end
   endtask

   task automatic check_bit(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Error: %0t %s got %b expected %b", $time, what, got, exp);
         $display("=== FAIL ===");
         $fatal(1, "Value mismatch on %s", what);
      end
   endtask

   task automatic tick();
      @(posedge clk);
      model_update();
      #1;
      csr_we     = 1'b0;
      wb_ex      = 1'b0;
      ertn_flush = 1'b0;
   endtask

   task automatic read_check(input csr_num_t n);
      csr_num = n;
      #4;
      if (model_known(n)) check_data("csr_rvalue", csr_rvalue, model_read(n));
      else if (n == `CSR_TCFG) check_bit("tcfg.en", csr_rvalue[`CSR_TCFG_EN], m_tcfg[0]);
      check_bit("has_int", has_int, model_has_int());
      if (eentry_known) check_data("ex_entry", ex_entry, {m_eentry, 6'd0});
      if (era_known) check_data("era", era, m_era);
      tick();
   endtask

   task automatic write_csr(input csr_num_t n, input csr_data_t mask, input csr_data_t val);
      csr_num    = n;
      csr_we     = 1'b1;
      csr_wmask  = mask;
      csr_wvalue = val;
      tick();
   endtask

   initial begin
      csr_num_t  n;
      int unsigned init;
      int unsigned sel;
      logic      per;
      void'($urandom(32'h744f9ddf));
      clk = 1'b0;
      resetn = 1'b0;
      csr_num = '0;
      csr_we = 1'b0;
      csr_wmask = '0;
      csr_wvalue = '0;
      hw_int_in = '0;
      ipi_int_in = 1'b0;
      coreid_in = $urandom;
      ertn_flush = 1'b0;
      wb_ex = 1'b0;
      wb_pc = '0;
      wb_vaddr = '0;
      wb_ecode = '0;
      wb_esubcode = '0;
      cycles = 0;
      {prmd_known, era_known, eentry_known, badv_known, tcfg_known} = '0;
      save_known = '0;
      m_tcfg = '0;
      kept_nums = '{`CSR_CRMD, `CSR_PRMD, `CSR_ECFG, `CSR_ESTAT, `CSR_ERA, `CSR_BADV,
                    `CSR_EENTRY, `CSR_SAVE0, `CSR_SAVE1, `CSR_SAVE2, `CSR_SAVE3,
                    `CSR_TID, `CSR_TCFG, `CSR_TVAL, `CSR_TICLR};
      repeat (16) tick();
      resetn = 1'b1;

      // Reset values
      for (int i = 0; i < 15; i++) read_check(kept_nums[i]);
      read_check(14'h3ff);

      // Full writes give every unreset register a known value
      write_csr(`CSR_PRMD, '1, $urandom);
      write_csr(`CSR_ERA, '1, $urandom);
      write_csr(`CSR_EENTRY, '1, $urandom);
      write_csr(`CSR_BADV, '1, $urandom);
      for (int i = 0; i < 4; i++) write_csr(csr_num_t'(`CSR_SAVE0 + i), '1, $urandom);
      write_csr(`CSR_TCFG, '1, {$urandom} & 32'hffff_fffe);

      for (int i = 0; i < N_RW; i++) begin
         n = ($urandom % 8 == 0) ? csr_num_t'($urandom) : kept_nums[$urandom % 15];
         write_csr(n, $urandom, $urandom);
         read_check(n);
      end

      for (int i = 0; i < N_EX; i++) begin
         sel = $urandom % 3;
         wb_ex = 1'b1;
         wb_pc = $urandom;
         wb_vaddr = $urandom;
         wb_ecode = (sel == 0) ? `ECODE_ADE : (sel == 1) ? `ECODE_ALE : ecode_t'($urandom);
         wb_esubcode = ($urandom % 2 == 0) ? `ESUBCODE_ADEF : esubcode_t'($urandom);
         tick();
         read_check(`CSR_CRMD);
         read_check(`CSR_PRMD);
         read_check(`CSR_ESTAT);
         read_check(`CSR_BADV);
         read_check(`CSR_ERA);
      end

      for (int i = 0; i < N_RET; i++) begin
         write_csr(`CSR_PRMD, 32'h7, $urandom);
         write_csr(`CSR_CRMD, 32'h1f, $urandom);
         ertn_flush = 1'b1;
         tick();
         read_check(`CSR_CRMD);
         read_check(`CSR_PRMD);
      end

      for (int i = 0; i < N_INT; i++) begin
         write_csr(`CSR_ESTAT, 32'h3, $urandom);
         write_csr(`CSR_ECFG, '1, $urandom);
         write_csr(`CSR_CRMD, 32'h4, $urandom);
         hw_int_in = hw_int_t'($urandom);
         ipi_int_in = 1'($urandom);
         read_check(`CSR_ESTAT);
         read_check(`CSR_ECFG);
         read_check(`CSR_CRMD);
      end
      hw_int_in = '0;
      ipi_int_in = 1'b0;

      // One-shot and periodic runs
      for (int t = 0; t < N_TMR; t++) begin
         per = 1'(t);
         init = $urandom_range(1, 6);
         write_csr(`CSR_TICLR, 32'h1, 32'h1);
         write_csr(`CSR_ECFG, '1, 32'h800);
         write_csr(`CSR_CRMD, 32'h4, 32'h4);
         write_csr(`CSR_TCFG, '1, {30'(init), per, 1'b1});
         for (int k = 0; k < int'(init) * 8 + 6; k++) read_check(`CSR_TVAL);
         read_check(`CSR_ESTAT);
         write_csr(`CSR_TICLR, 32'h1, 32'h1);
         read_check(`CSR_ESTAT);
         write_csr(`CSR_TCFG, 32'h1, 32'h0);
         read_check(`CSR_TVAL);
      end

      $display("=== PASS ===");
      $finish;
   end

endmodule

// File: csr_top.f
+incdir+rtl
rtl/csr_pkg.sv
rtl/csr_exc.sv
rtl/csr_int.sv
rtl/csr_timer.sv
rtl/csr_save.sv
rtl/csr_top.sv
testbench/csr_checker.sv
testbench/csr_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the CSR testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f csr_top.f --top-module csr_tb -o csr_sim &&
./obj_dir/csr_sim ||
exit 1
